/* build.f */
design/dau_pkg.sv
design/dau_stream_fifo.sv
design/dau_sequencer.sv
design/dau_loop_counters.sv
design/dau_datapath.sv
design/dau_top.sv
verif/tb_dau_top.sv

/* Bender.yml */
package:
  name: dau

sources:
  - design/dau_pkg.sv
  - design/dau_stream_fifo.sv
  - design/dau_sequencer.sv
  - design/dau_loop_counters.sv
  - design/dau_datapath.sv
  - design/dau_top.sv
  - target: test
    files:
      - verif/tb_dau_top.sv

/* verif/tb_dau_top.sv */
module tb_dau_top import dau_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [3:0] test;
        dau_cmd_t   cmd;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    logic        cmd_ready;
    dau_cmd_t    cmd_data;
    logic        res_valid;
    logic        res_ready;
    dau_res_t    res_data;

    entry_t      table_q[$];
    dau_res_t    exp_q[$];     // expected result words in order

    // reference model state
    logic [15:0] m_x;
    logic [15:0] m_y;
    logic [6:0]  m_auc;
    logic [31:0] m_p;
    logic [35:0] m_a0;
    logic [35:0] m_a1;
    logic [3:0]  m_flags;      // lmi leq llv lmv
    logic [7:0]  m_c0;
    logic [7:0]  m_c1;
    logic [7:0]  m_c2;

    integer      seed = 32'h65d;
    logic [31:0] rnd;
    int          hold_low;
    int          cur_test;
    int          start_err;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic        saw_stall;
    longint      limit;

    dau_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_data  (cmd_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task add_cmd(input logic [3:0] test, input dau_op_e op, input dau_cond_e cond,
                 input dau_reg_e sel, input logic acc, input logic [15:0] imm);
        entry_t e;
        e.test        = test;
        e.cmd.op      = op;
        e.cmd.cond    = cond;
        e.cmd.reg_sel = sel;
        e.cmd.acc_sel = acc;
        e.cmd.imm     = imm;
        table_q.push_back(e);
    endtask

    task build_table();
        for (int r = 0; r < 7; r++)
            add_cmd(1, op_read, c_true, dau_reg_e'(r), 0, 0);  // all zero after reset
        add_cmd(1, op_load, c_true, r_x, 0, 16'h1234);
        add_cmd(1, op_load, c_true, r_y, 0, 16'hfff0);
        add_cmd(1, op_load, c_true, r_auc, 0, 16'h00ff);
        add_cmd(1, op_load, c_true, r_c0, 0, 16'h01a5);
        add_cmd(1, op_load, c_true, r_c1, 0, 16'h0003);
        add_cmd(1, op_load, c_true, r_c2, 0, 16'h0080);
        for (int r = 0; r < 7; r++)
            add_cmd(1, op_read, c_true, dau_reg_e'(r), 0, 0);
        // multiply and accumulate with every product scale
        add_cmd(2, op_load, c_true, r_auc, 0, 16'h0000);
        add_cmd(2, op_mul, c_true, r_x, 0, 0);
        add_cmd(2, op_p2a, c_true, r_x, 0, 0);
        add_cmd(2, op_acc_hi, c_true, r_x, 0, 0);
        add_cmd(2, op_acc_lo, c_true, r_x, 0, 0);
        add_cmd(2, op_load, c_true, r_x, 0, 16'h8000);
        add_cmd(2, op_load, c_true, r_y, 0, 16'h7fff);
        add_cmd(2, op_pacc, c_true, r_x, 1, 0);
        add_cmd(2, op_load, c_true, r_auc, 0, 16'h0002);
        add_cmd(2, op_pacc, c_true, r_x, 1, 0);
        add_cmd(2, op_load, c_true, r_auc, 0, 16'h0001);
        add_cmd(2, op_psub, c_true, r_x, 0, 0);
        for (int a = 0; a < 2; a++) begin
            add_cmd(2, op_acc_hi, c_true, r_x, a[0], 0);
            add_cmd(2, op_acc_lo, c_true, r_x, a[0], 0);
        end
        add_cmd(3, op_load, c_true, r_y, 0, 16'h7fff);
        add_cmd(3, op_load, c_true, r_auc, 0, 16'h0000);
        add_cmd(3, op_yacc, c_true, r_x, 0, 0);
        add_cmd(3, op_read, c_true, r_psw, 0, 0);
        add_cmd(3, op_load, c_true, r_y, 0, 16'h00f0);
        add_cmd(3, op_yand, c_true, r_x, 1, 0);
        add_cmd(3, op_acc_lo, c_true, r_x, 1, 0);
        add_cmd(3, op_load, c_true, r_y, 0, 16'h8001);
        add_cmd(3, op_yor, c_true, r_x, 0, 0);
        add_cmd(3, op_read, c_true, r_psw, 0, 0);
        add_cmd(3, op_acc_hi, c_true, r_x, 0, 0);
        add_cmd(3, op_load, c_true, r_x, 0, 16'h7fff);
        add_cmd(3, op_load, c_true, r_y, 0, 16'h7fff);
        add_cmd(3, op_load, c_true, r_auc, 0, 16'h0002);
        add_cmd(3, op_mul, c_true, r_x, 0, 0);
        add_cmd(3, op_p2a, c_true, r_x, 0, 0);
        add_cmd(3, op_read, c_true, r_psw, 0, 0);
        add_cmd(3, op_read, c_lv, r_x, 0, 0);
        add_cmd(3, op_pacc, c_true, r_x, 0, 0);   // spills into the guard bits
        add_cmd(3, op_read, c_true, r_psw, 0, 0);
        // false conditions and flag conditions
        add_cmd(4, op_load, c_false, r_x, 0, 16'h5555);
        add_cmd(4, op_yacc, c_false, r_x, 0, 0);
        add_cmd(4, op_read, c_false, r_x, 0, 0);
        add_cmd(4, op_read, c_true, r_psw, 0, 0);
        add_cmd(4, op_read, c_true, r_x, 0, 0);
        add_cmd(4, op_acc_lo, c_true, r_x, 0, 0);
        add_cmd(4, op_load, c_true, r_y, 0, 16'h0000);
        add_cmd(4, op_yand, c_true, r_x, 1, 0);
        add_cmd(4, op_load, c_eq, r_x, 0, 16'h0001);
        add_cmd(4, op_load, c_ne, r_x, 0, 16'h0002);
        add_cmd(4, op_load, c_gt, r_x, 0, 16'h0003);
        add_cmd(4, op_load, c_mi, r_x, 0, 16'h0004);
        add_cmd(4, op_read, c_true, r_x, 0, 0);
        add_cmd(4, op_load, c_true, r_y, 0, 16'hffff);
        add_cmd(4, op_yacc, c_true, r_x, 1, 0);
        add_cmd(4, op_read, c_mi, r_y, 0, 0);
        add_cmd(4, op_read, c_gt, r_x, 0, 0);
        add_cmd(4, op_read, c_lv, r_x, 0, 0);
        add_cmd(4, op_read, c_pl, r_x, 0, 0);
        add_cmd(4, op_read, c_ne, r_psw, 0, 0);
        add_cmd(4, op_load, c_true, r_y, 0, 16'h0005);
        add_cmd(4, op_yand, c_true, r_x, 1, 0);   // small positive result
        add_cmd(4, op_read, c_gt, r_x, 0, 0);
        add_cmd(4, op_read, c_pl, r_y, 0, 0);
        // counter tests through the 127 to -128 wrap
        add_cmd(5, op_load, c_true, r_c0, 0, 16'h007e);
        add_cmd(5, op_load, c_c0lt, r_x, 0, 16'h0011);
        add_cmd(5, op_load, c_c0lt, r_x, 0, 16'h0022);
        add_cmd(5, op_load, c_c0lt, r_x, 0, 16'h0033);
        add_cmd(5, op_read, c_true, r_x, 0, 0);
        add_cmd(5, op_read, c_c0ge, r_c0, 0, 0);
        add_cmd(5, op_read, c_true, r_c0, 0, 0);
        add_cmd(5, op_load, c_true, r_c1, 0, 16'h007f);
        add_cmd(5, op_read, c_c1ge, r_y, 0, 0);
        add_cmd(5, op_read, c_c1ge, r_y, 0, 0);
        add_cmd(5, op_read, c_true, r_c1, 0, 0);
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 2)
                add_cmd(6, op_acc_hi, c_true, r_x, i[0], 0);
            else
                add_cmd(6, op_read, c_true, dau_reg_e'(i % 7), 0, 0);
        end
    endtask

    function automatic logic [15:0] reg_value(input dau_reg_e sel);
        case (sel)
            r_x:     return m_x;
            r_y:     return m_y;
            r_auc:   return {9'd0, m_auc};
            r_psw:   return {m_flags, 4'b0000, m_a1[35:32], m_a0[35:32]};
            r_c0:    return {8'd0, m_c0};
            r_c1:    return {8'd0, m_c1};
            r_c2:    return {8'd0, m_c2};
            default: return 16'd0;
        endcase
    endfunction

    // applies one instruction to the model and queues any expected result
    task automatic model_apply(input dau_cmd_t c);
        logic               take;
        logic               acc_upd;
        logic [35:0]        acc;
        logic [36:0]        acc_e;
        logic signed [36:0] ps;
        logic [36:0]        p_e;
        logic [36:0]        y_e;
        logic [36:0]        alu;
        dau_res_t           r;
        case (c.cond)
            c_true:  take = 1'b1;
            c_mi:    take = m_flags[3];
            c_pl:    take = ~m_flags[3];
            c_eq:    take = m_flags[2];
            c_ne:    take = ~m_flags[2];
            c_lv:    take = m_flags[1];
            c_c0ge:  take = ~m_c0[7];
            c_c0lt:  take = m_c0[7];
            c_c1ge:  take = ~m_c1[7];
            c_c1lt:  take = m_c1[7];
            c_gt:    take = ~m_flags[3] & ~m_flags[2];
            default: take = 1'b0;
        endcase
        acc   = c.acc_sel ? m_a1 : m_a0;
        acc_e = {acc[35], acc};
        ps    = $signed(m_p);
        case (m_auc[1:0])
            2'd1:    p_e = ps >>> 2;
            2'd2:    p_e = ps <<< 2;
            default: p_e = ps;
        endcase
        y_e = {{21{m_y[15]}}, m_y};
        // read value comes from the state before this instruction
        r.tag.acc = (c.op != op_read);
        r.tag.sel = (c.op == op_read) ? c.reg_sel : r_psw;
        r.data    = (c.op == op_acc_hi) ? acc[31:16] :
                    (c.op == op_acc_lo) ? acc[15:0] : reg_value(c.reg_sel);
        if (c.cond == c_c0ge || c.cond == c_c0lt)
            m_c0 = m_c0 + 8'd1;
        if (c.cond == c_c1ge || c.cond == c_c1lt)
            m_c1 = m_c1 + 8'd1;
        acc_upd = 1'b0;
        alu     = '0;
        if (take) begin
            case (c.op)
                op_load: begin
                    case (c.reg_sel)
                        r_x:     m_x   = c.imm;
                        r_y:     m_y   = c.imm;
                        r_auc:   m_auc = c.imm[6:0];
                        r_c0:    m_c0  = c.imm[7:0];
                        r_c1:    m_c1  = c.imm[7:0];
                        r_c2:    m_c2  = c.imm[7:0];
                        default: ;
                    endcase
                end
                op_mul:  m_p = $signed(m_x) * $signed(m_y);
                op_p2a:  {acc_upd, alu} = {1'b1, p_e};
                op_pacc: begin
                    {acc_upd, alu} = {1'b1, acc_e + p_e};
                    m_p = $signed(m_x) * $signed(m_y);
                end
                op_psub: {acc_upd, alu} = {1'b1, acc_e - p_e};
                op_yacc: {acc_upd, alu} = {1'b1, acc_e + y_e};
                op_yand: {acc_upd, alu} = {1'b1, acc_e & y_e};
                op_yor:  {acc_upd, alu} = {1'b1, acc_e | y_e};
                op_read, op_acc_hi, op_acc_lo: exp_q.push_back(r);
                default: ;
            endcase
        end
        if (acc_upd) begin
            if (c.acc_sel)
                m_a1 = alu[35:0];
            else
                m_a0 = alu[35:0];
            m_flags = {alu[35], alu[35:0] == 36'd0, ^alu[36:31], ^alu[35:31]};
        end
    endtask

    task send_cmd(input dau_cmd_t c);
        cmd_data  = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            if (cur_test == 6)
                saw_stall = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task finish_test(input int test);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        if (test == 6 && !saw_stall) begin
            $display("cmd_ready never dropped under back-pressure at time %0t", $time);
            errors++;
        end
        if (errors == start_err) begin
            tests_passed++;
            $display("test %0d passed", test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", test, errors - start_err);
        end
    endtask

    // res_ready is random, or held low for a stretch
    always @(posedge clk) begin
        #2;
        rnd = $random(seed);
        if (hold_low > 0) begin
            res_ready = 1'b0;
            hold_low  = hold_low - 1;
        end else begin
            res_ready = (rnd[1:0] != 2'b00);
        end
    end

    always @(negedge clk) begin
        if (!rst && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result %h at time %0t", res_data, $time);
                errors++;
            end else if (res_data !== exp_q[0]) begin
                $display("FAIL %0t: result expected %h got %h", $time, exp_q[0], res_data);
                errors++;
                void'(exp_q.pop_front());
            end else begin
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        res_ready = 1'b0;
        hold_low  = 0;
        cur_test  = 0;
        start_err = 0;
        errors    = 0;
        saw_stall = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        {m_x, m_y, m_auc, m_p, m_a0, m_a1, m_flags, m_c0, m_c1, m_c2} = '0;
        build_table();
        limit = table_q.size() * 20 * 40 + 8 * 40;
        fork
            begin
                #(limit);
                $display("timeout: results still missing after %0d ns", limit);
                $display("Simulation FAILED");
                $finish;
            end
        join_none
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            cur_test = table_q[i].test;
            if (i == 0 || table_q[i-1].test != cur_test) begin
                start_err = errors;
                if (cur_test == 6)
                    hold_low = 40;   // long stall before random ready
            end
            model_apply(table_q[i].cmd);
            send_cmd(table_q[i].cmd);
            if (i == table_q.size() - 1 || table_q[i+1].test != cur_test)
                finish_test(cur_test);
        end
        repeat (20) @(posedge clk);  // catch any stray results
        $display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* design/dau_top.sv */
module dau_top import dau_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  dau_cmd_t cmd_data,
    output logic     res_valid,
    input  logic     res_ready,
    output dau_res_t res_data
);

    logic        seq_cmd_valid;
    logic        seq_cmd_ready;
    dau_cmd_t    seq_cmd;
    logic        seq_res_valid;
    logic        seq_res_ready;
    dau_res_t    seq_res;
    dau_ctl_t    ctl;
    dau_flags_t  flags;
    logic        cnt_load;
    logic [1:0]  cnt_inc;
    logic        c0_neg;
    logic        c1_neg;
    logic [7:0]  cnt_value;
    logic [15:0] rd_value;

    dau_stream_fifo #(
        .payload_t (dau_cmd_t),
        .depth     (cmd_depth)
    ) cmd_fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cmd_valid),
        .in_data   (cmd_data),
        .in_ready  (cmd_ready),
        .out_valid (seq_cmd_valid),
        .out_ready (seq_cmd_ready),
        .out_data  (seq_cmd)
    );

    dau_sequencer seq0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (seq_cmd_valid),
        .cmd_ready (seq_cmd_ready),
        .cmd       (seq_cmd),
        .ctl       (ctl),
        .flags     (flags),
        .c0_neg    (c0_neg),
        .c1_neg    (c1_neg),
        .cnt_load  (cnt_load),
        .cnt_inc   (cnt_inc),
        .rd_value  (rd_value),
        .res_valid (seq_res_valid),
        .res_ready (seq_res_ready),
        .res       (seq_res)
    );

    // counter select and load byte come straight from the instruction
    dau_loop_counters cnt0 (
        .clk       (clk),
        .rst       (rst),
        .load      (cnt_load),
        .sel       (ctl.reg_sel),
        .imm       (ctl.imm[7:0]),
        .inc       (cnt_inc),
        .c0_neg    (c0_neg),
        .c1_neg    (c1_neg),
        .cnt_value (cnt_value)
    );

    dau_datapath dp0 (
        .clk       (clk),
        .rst       (rst),
        .ctl       (ctl),
        .cnt_value (cnt_value),
        .flags     (flags),
        .rd_value  (rd_value)
    );

    dau_stream_fifo #(
        .payload_t (dau_res_t),
        .depth     (res_depth)
    ) res_fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (seq_res_valid),
        .in_data   (seq_res),
        .in_ready  (seq_res_ready),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_data)
    );

endmodule

/* design/dau_datapath.sv */
module dau_datapath import dau_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dau_ctl_t    ctl,
    input  logic [7:0]  cnt_value,
    output dau_flags_t  flags,
    output logic [15:0] rd_value
);

    logic [15:0]        x;
    logic [15:0]        y;
    logic [6:0]         auc;       // bits 1:0 scale the product
    logic [31:0]        p;
    logic signed [31:0] prod;
    logic [acc_w-1:0]   a0;
    logic [acc_w-1:0]   a1;
    logic [acc_w-1:0]   acc_src;
    logic [acc_w:0]     acc_ext;
    logic [acc_w:0]     p_ext;
    logic [acc_w:0]     y_ext;
    logic [acc_w:0]     alu;       // one bit above the accumulator for llv
    logic [15:0]        psw;
    logic               acc_op;
    logic               load;

    assign load    = ctl.exec && (ctl.op == op_load);
    assign prod    = $signed(x) * $signed(y);
    assign acc_src = ctl.acc_sel ? a1 : a0;
    assign acc_ext = {acc_src[acc_w-1], acc_src};
    assign y_ext   = {{(acc_w-15){y[15]}}, y};

    // flags on top, guard bits of both accumulators at the bottom
    assign psw = {flags, 4'b0000, a1[acc_w-1:32], a0[acc_w-1:32]};

    always_comb begin
        case (auc[1:0])
            2'd0:    p_ext = {{(acc_w-31){p[31]}}, p};
            2'd2:    p_ext = {{(acc_w-33){p[31]}}, p, 2'b00};  // left by 2
            default: p_ext = {{(acc_w-29){p[31]}}, p[31:2]};   // 1 and 3 shift right by 2
        endcase
    end

    always_comb begin
        acc_op = 1'b1;
        case (ctl.op)
            op_p2a:  alu = p_ext;
            op_pacc: alu = acc_ext + p_ext;
            op_psub: alu = acc_ext - p_ext;
            op_yacc: alu = acc_ext + y_ext;
            op_yand: alu = acc_ext & y_ext;
            op_yor:  alu = acc_ext | y_ext;
            default: begin
                alu    = acc_ext;
                acc_op = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x     <= '0;
            y     <= '0;
            auc   <= '0;
            p     <= '0;
            a0    <= '0;
            a1    <= '0;
            flags <= '0;
        end else begin
            if (load && ctl.reg_sel == r_x)
                x <= ctl.imm;
            if (load && ctl.reg_sel == r_y)
                y <= ctl.imm;
            if (load && ctl.reg_sel == r_auc)
                auc <= ctl.imm[6:0];

            // pacc adds the old product while the new one is formed
            if (ctl.exec && (ctl.op == op_mul || ctl.op == op_pacc))
                p <= prod;

            if (ctl.exec && acc_op) begin
                if (ctl.acc_sel)
                    a1 <= alu[acc_w-1:0];
                else
                    a0 <= alu[acc_w-1:0];
                flags.lmi <= alu[acc_w-1];
                flags.leq <= ~|alu[acc_w-1:0];
                flags.llv <= ^alu[acc_w:acc_w-5];    // bits 36..31
                flags.lmv <= ^alu[acc_w-1:acc_w-5];  // bits 35..31
            end
        end
    end

    // read port follows the instruction in exec
    always_comb begin
        case (ctl.op)
            op_acc_hi: rd_value = acc_src[31:16];
            op_acc_lo: rd_value = acc_src[15:0];
            default: begin
                case (ctl.reg_sel)
                    r_x:     rd_value = x;
                    r_y:     rd_value = y;
                    r_auc:   rd_value = {9'd0, auc};
                    r_psw:   rd_value = psw;
                    r_c0,
                    r_c1,
                    r_c2:    rd_value = {8'd0, cnt_value};
                    default: rd_value = 16'd0;
                endcase
            end
        endcase
    end

endmodule

/* design/dau_loop_counters.sv */
module dau_loop_counters import dau_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  dau_reg_e   sel,
    input  logic [7:0] imm,
    input  logic [1:0] inc,
    output logic       c0_neg,
    output logic       c1_neg,
    output logic [7:0] cnt_value
);

    logic [7:0] c0;
    logic [7:0] c1;
    logic [7:0] c2;   // no test condition, load and read only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            c0 <= '0;
            c1 <= '0;
            c2 <= '0;
        end else begin
            // load wins over the increment from the same instruction
            if (load && sel == r_c0)
                c0 <= imm;
            else if (inc[0])
                c0 <= c0 + 8'd1;  // 127 wraps to -128

            if (load && sel == r_c1)
                c1 <= imm;
            else if (inc[1])
                c1 <= c1 + 8'd1;

            if (load && sel == r_c2)
                c2 <= imm;
        end
    end

    assign c0_neg = c0[7];
    assign c1_neg = c1[7];

    always_comb begin
        case (sel)
            r_c0:    cnt_value = c0;
            r_c1:    cnt_value = c1;
            r_c2:    cnt_value = c2;
            default: cnt_value = 8'd0;
        endcase
    end

endmodule

/* design/dau_sequencer.sv */
module dau_sequencer import dau_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  dau_cmd_t    cmd,
    output dau_ctl_t    ctl,
    input  dau_flags_t  flags,
    input  logic        c0_neg,
    input  logic        c1_neg,
    output logic        cnt_load,
    output logic [1:0]  cnt_inc,     // bit 0 c0, bit 1 c1
    input  logic [15:0] rd_value,
    output logic        res_valid,
    input  logic        res_ready,
    output dau_res_t    res
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_push
    } state_e;

    state_e state;
    logic   in_exec;
    logic   cond_ok;
    logic   is_read;

    assign in_exec = (state == st_exec);
    assign is_read = (cmd.op == op_read) || (cmd.op == op_acc_hi) || (cmd.op == op_acc_lo);

    // flags and counter signs are the values registered before this edge
    always_comb begin
        case (cmd.cond)
            c_true:  cond_ok = 1'b1;
            c_false: cond_ok = 1'b0;
            c_mi:    cond_ok = flags.lmi;
            c_pl:    cond_ok = ~flags.lmi;
            c_eq:    cond_ok = flags.leq;
            c_ne:    cond_ok = ~flags.leq;
            c_lv:    cond_ok = flags.llv;
            c_c0ge:  cond_ok = ~c0_neg;
            c_c0lt:  cond_ok = c0_neg;
            c_c1ge:  cond_ok = ~c1_neg;
            c_c1lt:  cond_ok = c1_neg;
            c_gt:    cond_ok = ~flags.lmi & ~flags.leq;
            default: cond_ok = 1'b0;
        endcase
    end

    assign cmd_ready = in_exec;   // head is popped in exec
    assign res_valid = (state == st_push);

    always_comb begin
        ctl.exec    = in_exec && cond_ok;  // false condition gives a no-op
        ctl.op      = cmd.op;
        ctl.reg_sel = cmd.reg_sel;
        ctl.acc_sel = cmd.acc_sel;
        ctl.imm     = cmd.imm;
    end

    assign cnt_load = in_exec && cond_ok && (cmd.op == op_load);

    // counter is bumped whatever the outcome of the test
    assign cnt_inc[0] = in_exec && (cmd.cond == c_c0ge || cmd.cond == c_c0lt);
    assign cnt_inc[1] = in_exec && (cmd.cond == c_c1ge || cmd.cond == c_c1lt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (cmd_valid) state <= st_exec;
                st_exec: state <= (cond_ok && is_read) ? st_push : st_idle;
                st_push: if (res_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // result word held until the result fifo takes it
    always_ff @(posedge clk) begin
        if (in_exec && is_read) begin
            res.data    <= rd_value;
            res.tag.acc <= (cmd.op != op_read);
            res.tag.sel <= (cmd.op == op_read) ? cmd.reg_sel : r_psw;
        end
    end

endmodule

/* design/dau_stream_fifo.sv */
module dau_stream_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t                     mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth+1)-1:0]   count;
    logic                         push;
    logic                         pop;

    assign in_ready  = (count != depth);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // entry storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule

/* design/dau_pkg.sv */
package dau_pkg;

    localparam int cmd_depth = 4;   // command fifo entries
    localparam int res_depth = 4;   // result fifo entries
    localparam int acc_w     = 36;  // 32 data bits plus 4 guard bits

    // instruction opcodes
    typedef enum logic [3:0] {
        op_nop    = 4'd0,
        op_load   = 4'd1,   // register named by reg_sel gets imm
        op_mul    = 4'd2,   // p = x * y
        op_p2a    = 4'd3,   // acc = p
        op_pacc   = 4'd4,   // acc = acc + p and p = x * y
        op_psub   = 4'd5,   // acc = acc - p
        op_yacc   = 4'd6,   // acc = acc + y
        op_yand   = 4'd7,
        op_yor    = 4'd8,
        op_read   = 4'd9,   // push register to result stream
        op_acc_hi = 4'd10,  // push acc[31:16]
        op_acc_lo = 4'd11   // push acc[15:0]
    } dau_op_e;

    typedef enum logic [3:0] {
        c_true  = 4'd0,
        c_false = 4'd1,
        c_mi    = 4'd2,
        c_pl    = 4'd3,
        c_eq    = 4'd4,
        c_ne    = 4'd5,
        c_lv    = 4'd6,
        c_c0ge  = 4'd7,   // counter conditions bump the counter when tested
        c_c0lt  = 4'd8,
        c_c1ge  = 4'd9,
        c_c1lt  = 4'd10,
        c_gt    = 4'd11   // not minus and not zero
    } dau_cond_e;

    typedef enum logic [2:0] {
        r_x   = 3'd0,
        r_y   = 3'd1,
        r_auc = 3'd2,
        r_psw = 3'd3,
        r_c0  = 3'd4,
        r_c1  = 3'd5,
        r_c2  = 3'd6
    } dau_reg_e;

    typedef struct packed {
        dau_op_e     op;
        dau_cond_e   cond;
        dau_reg_e    reg_sel;
        logic        acc_sel;  // 0 a0, 1 a1
        logic [15:0] imm;
    } dau_cmd_t;

    // result tag for accumulator words is r_psw with acc set
    typedef struct packed {
        logic     acc;
        dau_reg_e sel;
    } dau_tag_t;

    typedef struct packed {
        logic [15:0] data;
        dau_tag_t    tag;
    } dau_res_t;

    typedef struct packed {
        logic        exec;     // instruction takes effect this cycle
        dau_op_e     op;
        dau_reg_e    reg_sel;
        logic        acc_sel;
        logic [15:0] imm;
    } dau_ctl_t;

    typedef struct packed {
        logic lmi;
        logic leq;
        logic llv;
        logic lmv;
    } dau_flags_t;

endpackage
